// File: include/icache_config.svh
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// Cache geometry
`define ICACHE_LINES 16
`define ADDR_BITS 32
`define ITAG_BITS 13
`define OFFSET_BITS 3
`define ZERO_BITS 16
`define BLOCK_BITS 64
`define LINE_BYTES 8

// Memory interface, tag zero means no tag
`define MEM_TAG_BITS 4
`define MSHR_DEPTH 16

// Victim LFSR, x^4 + x^3 + 1 in Galois form
`define LFSR_SEED 'h9
`define LFSR_TAPS 'hC

`endif

// File: hw/icache_pkg.sv
`default_nettype none

`include "icache_config.svh"

package icache_pkg;

    // Byte address split into unused upper bits, line tag and offset
    typedef struct packed {
        logic [`ZERO_BITS-1:0]   zeros;
        logic [`ITAG_BITS-1:0]   tag;
        logic [`OFFSET_BITS-1:0] offset;
    } i_addr_t;

    typedef struct packed {
        logic    valid;
        i_addr_t addr;
    } addr_pkt_t;

    // Read port result, valid means hit
    typedef struct packed {
        logic                   valid;
        logic [`BLOCK_BITS-1:0] data;
    } cache_data_t;

    // Stored line and fill write share this layout
    typedef struct packed {
        logic                   valid;
        logic [`ITAG_BITS-1:0]  tag;
        logic [`BLOCK_BITS-1:0] data;
    } cache_line_t;

    typedef struct packed {
        logic                     valid;
        logic [`MEM_TAG_BITS-1:0] mem_tag;
        logic [`ITAG_BITS-1:0]    i_tag;
    } mshr_entry_t;

    typedef struct packed {
        logic [`MEM_TAG_BITS-1:0] tag;
        logic [`BLOCK_BITS-1:0]   data;
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: hw/icache_line.sv
`timescale 1ns/1ns
`default_nettype none

module icache_line (
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire logic                     i_write_enable,
    input  wire icache_pkg::cache_line_t  i_write_line,
    output icache_pkg::cache_line_t       o_line
);

    icache_pkg::cache_line_t line_q;

    // Single entry of the fully associative array
    always_ff @(posedge clock) begin
        if (reset) begin
            line_q <= '0;
        end else if (i_write_enable) begin
            line_q <= i_write_line;
        end
    end

    assign o_line = line_q;

endmodule

`default_nettype wire

// File: hw/icache_fill_select.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_config.svh"

module icache_fill_select (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire icache_pkg::cache_line_t   i_fill,
    input  wire logic [`ICACHE_LINES-1:0]  i_line_valids,
    output logic [`ICACHE_LINES-1:0]       o_write_enable,
    output icache_pkg::cache_line_t        o_write_line
);

    localparam int IDX_BITS = $clog2(`ICACHE_LINES);

    logic [IDX_BITS-1:0]      lfsr;
    logic [IDX_BITS-1:0]      lfsr_next;
    logic [`ICACHE_LINES-1:0] free_lines;
    logic [`ICACHE_LINES-1:0] first_free;
    logic [`ICACHE_LINES-1:0] victim;

    // Galois step, the state never reaches zero
    assign lfsr_next = {1'b0, lfsr[IDX_BITS-1:1]} ^
                       (lfsr[0] ? IDX_BITS'(`LFSR_TAPS) : '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            lfsr <= IDX_BITS'(`LFSR_SEED);
        end else begin
            lfsr <= lfsr_next;
        end
    end

    // Lowest set bit of the free mask
    assign free_lines = ~i_line_valids;
    assign first_free = free_lines & (~free_lines + 1'b1);

    assign victim = `ICACHE_LINES'(1) << lfsr;

    always_comb begin
        o_write_enable = '0;
        if (i_fill.valid) begin
            if (|free_lines) begin
                o_write_enable = first_free;
            end else begin
                o_write_enable = victim;
            end
        end
    end

    assign o_write_line = i_fill;

endmodule

`default_nettype wire

// File: hw/icache_lookup.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_config.svh"

module icache_lookup (
    input  wire icache_pkg::cache_line_t [`ICACHE_LINES-1:0] i_lines,
    input  wire icache_pkg::addr_pkt_t [1:0]                 i_read_addrs,
    input  wire icache_pkg::addr_pkt_t                       i_snoop,
    output icache_pkg::cache_data_t [1:0]                    o_cache_outs,
    output logic                                             o_snoop_hit,
    output logic                                             o_full,
    output icache_pkg::addr_pkt_t                            o_oldest_miss,
    output logic [`ICACHE_LINES-1:0]                         o_line_valids
);

    logic [1:0][`ICACHE_LINES-1:0] read_match;
    logic [`ICACHE_LINES-1:0]      snoop_match;

    for (genvar i = 0; i < `ICACHE_LINES; i++) begin : g_match
        assign o_line_valids[i] = i_lines[i].valid;

        assign snoop_match[i] = i_lines[i].valid &&
                                (i_lines[i].tag == i_snoop.addr.tag);

        for (genvar p = 0; p < 2; p++) begin : g_port
            assign read_match[p][i] = i_read_addrs[p].valid && i_lines[i].valid &&
                                      (i_lines[i].tag == i_read_addrs[p].addr.tag);
        end
    end

    // Tags are unique, so at most one masked block is nonzero
    always_comb begin
        o_cache_outs = '0;
        for (int p = 0; p < 2; p++) begin
            o_cache_outs[p].valid = |read_match[p];
            for (int i = 0; i < `ICACHE_LINES; i++) begin
                o_cache_outs[p].data = o_cache_outs[p].data |
                    (i_lines[i].data & {`BLOCK_BITS{read_match[p][i]}});
            end
        end
    end

    assign o_snoop_hit = i_snoop.valid && (|snoop_match);
    assign o_full      = &o_line_valids;

    // Older port wins
    always_comb begin
        o_oldest_miss = '0;
        if (i_read_addrs[0].valid && !o_cache_outs[0].valid) begin
            o_oldest_miss = i_read_addrs[0];
        end else if (i_read_addrs[1].valid && !o_cache_outs[1].valid) begin
            o_oldest_miss = i_read_addrs[1];
        end
    end

endmodule

`default_nettype wire

// File: hw/icache_prefetcher.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_config.svh"

module icache_prefetcher (
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire icache_pkg::addr_pkt_t  i_oldest_miss,
    input  wire logic                   i_full,
    input  wire logic                   i_handled,
    output icache_pkg::addr_pkt_t       o_snoop
);

    icache_pkg::addr_pkt_t last_demand;
    icache_pkg::addr_pkt_t next_last_demand;
    icache_pkg::i_addr_t   lookahead;
    icache_pkg::i_addr_t   next_lookahead;
    icache_pkg::i_addr_t   lookahead_step;
    logic                  new_demand;

    assign lookahead_step = icache_pkg::i_addr_t'(lookahead + `ADDR_BITS'(`LINE_BYTES));

    // Miss not yet requested, or nothing recorded so far
    assign new_demand = i_oldest_miss.valid &&
                        (!last_demand.valid || (i_oldest_miss.addr != last_demand.addr));

    always_comb begin
        o_snoop          = '0;
        next_last_demand = last_demand;
        next_lookahead   = lookahead;
        if (new_demand) begin
            o_snoop = i_oldest_miss;
            if (i_handled) begin
                next_last_demand = i_oldest_miss;
                next_lookahead   = i_oldest_miss.addr;
            end
        end else if (!i_full && last_demand.valid) begin
            // Next-line lookahead
            o_snoop.valid = 1'b1;
            o_snoop.addr  = lookahead_step;
            if (i_handled) begin
                next_lookahead = lookahead_step;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            last_demand <= '0;
            lookahead   <= '0;
        end else begin
            last_demand <= next_last_demand;
            lookahead   <= next_lookahead;
        end
    end

endmodule

`default_nettype wire

// File: hw/icache_mshr.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_config.svh"

module icache_mshr (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire icache_pkg::addr_pkt_t     i_snoop,
    input  wire logic                      i_cache_hit,
    input  wire logic                      i_mem_req_accepted,
    input  wire logic [`MEM_TAG_BITS-1:0]  i_current_req_tag,
    input  wire icache_pkg::mem_rsp_t      i_mem_rsp,
    output icache_pkg::addr_pkt_t          o_mem_req,
    output logic                           o_skip,
    output icache_pkg::cache_line_t        o_fill
);

    localparam int PTR_BITS = $clog2(`MSHR_DEPTH);

    icache_pkg::mshr_entry_t [`MSHR_DEPTH-1:0] entries;
    icache_pkg::mshr_entry_t [`MSHR_DEPTH-1:0] next_entries;
    icache_pkg::mshr_entry_t                   head_entry;
    logic [PTR_BITS-1:0]                       head;
    logic [PTR_BITS-1:0]                       tail;
    logic [PTR_BITS-1:0]                       next_head;
    logic [PTR_BITS-1:0]                       next_tail;
    logic [`MSHR_DEPTH-1:0]                    pending_match;
    logic                                      pending_hit;
    logic                                      push;
    logic                                      pop;

    // Line already on its way from memory
    for (genvar i = 0; i < `MSHR_DEPTH; i++) begin : g_snoop
        assign pending_match[i] = entries[i].valid &&
                                  (entries[i].i_tag == i_snoop.addr.tag);
    end
    assign pending_hit = |pending_match;

    always_comb begin
        o_mem_req = '0;
        o_skip    = 1'b0;
        if (i_snoop.valid) begin
            if (i_cache_hit || pending_hit) begin
                o_skip = 1'b1;
            end else begin
                o_mem_req = i_snoop;
            end
        end
    end

    assign head_entry = entries[head];

    // Zero tag means refused or no response
    assign push = i_mem_req_accepted && o_mem_req.valid && (i_current_req_tag != '0);
    assign pop  = (i_mem_rsp.tag != '0) && head_entry.valid &&
                  (head_entry.mem_tag == i_mem_rsp.tag);

    always_comb begin
        next_entries = entries;
        next_head    = head;
        next_tail    = tail;
        if (pop) begin
            next_entries[head].valid = 1'b0;
            next_head = head + 1'b1;
        end
        if (push) begin
            next_entries[tail].valid   = 1'b1;
            next_entries[tail].mem_tag = i_current_req_tag;
            next_entries[tail].i_tag   = o_mem_req.addr.tag;
            next_tail = tail + 1'b1;
        end
    end

    // Write into the cache at the popping edge
    always_comb begin
        o_fill       = '0;
        o_fill.valid = pop;
        o_fill.tag   = head_entry.i_tag;
        o_fill.data  = i_mem_rsp.data;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entries <= '0;
            head    <= '0;
            tail    <= '0;
        end else begin
            entries <= next_entries;
            head    <= next_head;
            tail    <= next_tail;
        end
    end

endmodule

`default_nettype wire

// File: hw/icache_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_config.svh"

module icache_subsystem (
    input  wire logic                          clock,
    input  wire logic                          reset,

    // Fetch side, port 0 is the older instruction
    input  wire icache_pkg::addr_pkt_t [1:0]   i_read_addrs,
    output icache_pkg::cache_data_t [1:0]      o_cache_outs,

    // Memory side
    input  wire logic                          i_mem_req_accepted,
    input  wire logic [`MEM_TAG_BITS-1:0]      i_current_req_tag,
    input  wire icache_pkg::mem_rsp_t          i_mem_rsp,
    output icache_pkg::addr_pkt_t              o_mem_req
);

    icache_pkg::cache_line_t                     fill_line;
    icache_pkg::cache_line_t                     write_line;
    logic [`ICACHE_LINES-1:0]                    write_enable;
    logic [`ICACHE_LINES-1:0]                    line_valids;
    icache_pkg::cache_line_t [`ICACHE_LINES-1:0] lines;
    icache_pkg::addr_pkt_t                       snoop_addr;
    icache_pkg::addr_pkt_t                       oldest_miss;
    logic                                        snoop_hit;
    logic                                        cache_full;
    logic                                        skip;
    logic                                        handled;

    // Filtered requests count as done so the prefetcher moves on
    assign handled = i_mem_req_accepted | skip;

    icache_fill_select u_fill_select (
        .clock          (clock),
        .reset          (reset),
        .i_fill         (fill_line),
        .i_line_valids  (line_valids),
        .o_write_enable (write_enable),
        .o_write_line   (write_line)
    );

    for (genvar i = 0; i < `ICACHE_LINES; i++) begin : g_line
        icache_line u_line (
            .clock          (clock),
            .reset          (reset),
            .i_write_enable (write_enable[i]),
            .i_write_line   (write_line),
            .o_line         (lines[i])
        );
    end

    icache_lookup u_lookup (
        .i_lines        (lines),
        .i_read_addrs   (i_read_addrs),
        .i_snoop        (snoop_addr),
        .o_cache_outs   (o_cache_outs),
        .o_snoop_hit    (snoop_hit),
        .o_full         (cache_full),
        .o_oldest_miss  (oldest_miss),
        .o_line_valids  (line_valids)
    );

    icache_prefetcher u_prefetcher (
        .clock          (clock),
        .reset          (reset),
        .i_oldest_miss  (oldest_miss),
        .i_full         (cache_full),
        .i_handled      (handled),
        .o_snoop        (snoop_addr)
    );

    icache_mshr u_mshr (
        .clock              (clock),
        .reset              (reset),
        .i_snoop            (snoop_addr),
        .i_cache_hit        (snoop_hit),
        .i_mem_req_accepted (i_mem_req_accepted),
        .i_current_req_tag  (i_current_req_tag),
        .i_mem_rsp          (i_mem_rsp),
        .o_mem_req          (o_mem_req),
        .o_skip             (skip),
        .o_fill             (fill_line)
    );

endmodule

`default_nettype wire

// File: sim/icache_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_config.svh"

module icache_mem_model #(
    parameter logic [31:0] SEED = 32'h1
) (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire icache_pkg::addr_pkt_t     i_mem_req,
    output logic                           o_mem_req_accepted,
    output logic [`MEM_TAG_BITS-1:0]       o_current_req_tag,
    output icache_pkg::mem_rsp_t           o_mem_rsp
);

    integer                   seed;
    integer                   cycle;
    logic [`MEM_TAG_BITS-1:0] next_tag;
    icache_pkg::mem_rsp_t     rsp;
    logic [`MEM_TAG_BITS-1:0] tag_queue[$];
    logic [`ITAG_BITS-1:0]    line_queue[$];
    integer                   due_queue[$];

    // Line tag repeated in every 16-bit word, then scrambled
    function automatic logic [`BLOCK_BITS-1:0] block_for(input logic [`ITAG_BITS-1:0] line_tag);
        logic [15:0] word;
        word = {3'b000, line_tag};
        return {4{word}} ^ 64'h5a3c_96f0_0ff0_c35a;
    endfunction

    initial begin
        seed               = SEED;
        cycle              = 0;
        next_tag           = 1;
        o_mem_req_accepted = 1'b0;
        o_current_req_tag  = '0;
        o_mem_rsp          = '0;
    end

    always @(posedge clock) begin
        if (reset) begin
            cycle    = 0;
            next_tag = 1;
            tag_queue.delete();
            line_queue.delete();
            due_queue.delete();
            o_mem_req_accepted <= 1'b0;
            o_current_req_tag  <= '0;
            o_mem_rsp          <= '0;
        end else begin
            cycle = cycle + 1;
            // Request taken during the cycle that just ended
            if (o_mem_req_accepted && i_mem_req.valid) begin
                tag_queue.push_back(o_current_req_tag);
                line_queue.push_back(i_mem_req.addr.tag);
                due_queue.push_back(cycle + 1 + {$random(seed)} % 8);
                next_tag = (next_tag == 15) ? 4'd1 : next_tag + 1'b1;
            end
            // Oldest request first with one response per cycle
            rsp = '0;
            if (due_queue.size() > 0 && due_queue[0] <= cycle) begin
                void'(due_queue.pop_front());
                rsp.tag  = tag_queue.pop_front();
                rsp.data = block_for(line_queue.pop_front());
            end
            o_mem_rsp          <= rsp;
            o_mem_req_accepted <= ({$random(seed)} % 3) != 0;
            o_current_req_tag  <= next_tag;
        end
    end

endmodule

`default_nettype wire

// File: sim/icache_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_config.svh"

module icache_tb;

    localparam int PERIOD         = 100;
    localparam int RESET_CYCLES   = 16;
    localparam int DIRECTED_LIMIT = 200;
    localparam int RANDOM_CYCLES  = 3000;
    localparam int NUM_TAGS       = 24;
    localparam logic [`ITAG_BITS-1:0] DIRECTED_TAG = 13'h1a5c;

    logic                          clock;
    logic                          reset;
    icache_pkg::addr_pkt_t [1:0]   read_addrs;
    icache_pkg::cache_data_t [1:0] cache_outs;
    icache_pkg::addr_pkt_t         mem_req;
    logic                          mem_req_accepted;
    logic [`MEM_TAG_BITS-1:0]      current_req_tag;
    icache_pkg::mem_rsp_t          mem_rsp;

    integer seed;
    integer error_count;
    integer fill_count;
    logic   directed_active;
    logic   directed_returned;
    logic   directed_done;

    // Memory traffic seen so far in request order
    logic [`MEM_TAG_BITS-1:0] sent_mem_tags[$];
    logic [`ITAG_BITS-1:0]    sent_line_tags[$];
    bit                       outstanding [0:(1 << `ITAG_BITS) - 1];
    bit                       returned [0:(1 << `ITAG_BITS) - 1];

    // Reference prefetcher state
    logic        have_demand;
    logic [31:0] last_demand;
    logic [31:0] prev_handled;

    icache_subsystem dut (
        .clock              (clock),
        .reset              (reset),
        .i_read_addrs       (read_addrs),
        .o_cache_outs       (cache_outs),
        .i_mem_req_accepted (mem_req_accepted),
        .i_current_req_tag  (current_req_tag),
        .i_mem_rsp          (mem_rsp),
        .o_mem_req          (mem_req)
    );

    icache_mem_model #(.SEED(32'hdbc5b9de)) u_mem_model (
        .clock              (clock),
        .reset              (reset),
        .i_mem_req          (mem_req),
        .o_mem_req_accepted (mem_req_accepted),
        .o_current_req_tag  (current_req_tag),
        .o_mem_rsp          (mem_rsp)
    );

    always #(PERIOD / 2) clock = ~clock;

    task automatic stop_on_failure();
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: actual 0x%h expected 0x%h", name, actual, expected);
            error_count = error_count + 1;
            stop_on_failure();
        end
    endtask

    function automatic logic [`BLOCK_BITS-1:0] expected_block(input logic [`ITAG_BITS-1:0] t);
        return {4{{3'b000, t}}} ^ 64'h5a3c_96f0_0ff0_c35a;
    endfunction

    function automatic icache_pkg::addr_pkt_t make_addr(input logic valid,
                                                        input logic [`ITAG_BITS-1:0] t,
                                                        input logic [2:0] offset);
        icache_pkg::addr_pkt_t pkt;
        pkt             = '0;
        pkt.valid       = valid;
        pkt.addr.tag    = t;
        pkt.addr.offset = offset;
        return pkt;
    endfunction

    // Hit data must follow the block rule of a line memory has returned
    task automatic check_hits();
        logic [`ITAG_BITS-1:0] t;
        for (int p = 0; p < 2; p++) begin
            if (cache_outs[p].valid) begin
                t = read_addrs[p].addr.tag;
                check_value("o_cache_outs.data", cache_outs[p].data, expected_block(t));
                if (!returned[t]) begin
                    $display("Port %0d hit on line tag 0x%h before memory returned it", p, t);
                    stop_on_failure();
                end
            end
        end
    endtask

    task automatic check_request();
        icache_pkg::addr_pkt_t miss;
        logic                  new_demand;
        logic                  handled;
        miss = '0;
        if (read_addrs[0].valid && !cache_outs[0].valid) begin
            miss = read_addrs[0];
        end else if (read_addrs[1].valid && !cache_outs[1].valid) begin
            miss = read_addrs[1];
        end
        if (mem_req.valid && outstanding[mem_req.addr.tag]) begin
            $display("Request for line tag 0x%h while it is still outstanding",
                     mem_req.addr.tag);
            stop_on_failure();
        end
        // No request while a candidate exists means the filter skipped it
        handled    = mem_req_accepted || !mem_req.valid;
        new_demand = miss.valid && (!have_demand || miss.addr != last_demand);
        if (new_demand) begin
            if (mem_req.valid) begin
                check_value("o_mem_req.addr", mem_req.addr, miss.addr);
            end
            if (handled) begin
                have_demand  = 1'b1;
                last_demand  = miss.addr;
                prev_handled = miss.addr;
            end
        end else if (fill_count < `ICACHE_LINES && have_demand) begin
            if (mem_req.valid) begin
                check_value("o_mem_req.addr", mem_req.addr, prev_handled + `LINE_BYTES);
            end
            if (handled) begin
                prev_handled = prev_handled + `LINE_BYTES;
            end
        end else begin
            check_value("o_mem_req.valid", mem_req.valid, 1'b0);
        end
    endtask

    task automatic track_memory();
        logic [`MEM_TAG_BITS-1:0] mem_tag;
        logic [`ITAG_BITS-1:0]    line;
        if (mem_req.valid && mem_req_accepted && current_req_tag != '0) begin
            sent_mem_tags.push_back(current_req_tag);
            sent_line_tags.push_back(mem_req.addr.tag);
            outstanding[mem_req.addr.tag] = 1'b1;
        end
        if (mem_rsp.tag != '0) begin
            if (sent_mem_tags.size() == 0) begin
                $display("Memory response with tag 0x%h but no request pending", mem_rsp.tag);
                stop_on_failure();
            end
            mem_tag = sent_mem_tags.pop_front();
            line    = sent_line_tags.pop_front();
            check_value("i_mem_rsp.tag", mem_rsp.tag, mem_tag);
            outstanding[line] = 1'b0;
            returned[line]    = 1'b1;
            fill_count        = fill_count + 1;
            if (directed_active && line == DIRECTED_TAG) begin
                directed_returned = 1'b1;
            end
        end
    endtask

    // Sample mid-cycle when all outputs have settled
    always @(negedge clock) begin
        if (!reset) begin
            if (directed_returned) begin
                check_value("o_cache_outs[0].valid", cache_outs[0].valid, 1'b1);
                directed_returned = 1'b0;
                directed_done     = 1'b1;
            end
            check_hits();
            check_request();
            track_memory();
        end
    end

    initial begin
        seed              = 32'hdbc5b9de;
        error_count       = 0;
        fill_count        = 0;
        directed_active   = 1'b0;
        directed_returned = 1'b0;
        directed_done     = 1'b0;
        have_demand       = 1'b0;
        last_demand       = '0;
        prev_handled      = '0;
        clock             = 1'b0;
        reset             = 1'b1;
        read_addrs        = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value("o_mem_req.valid", mem_req.valid, 1'b0);
        check_value("o_cache_outs[0].valid", cache_outs[0].valid, 1'b0);
        check_value("o_cache_outs[1].valid", cache_outs[1].valid, 1'b0);

        // Port 0 parked on a line that is not cached
        @(posedge clock);
        read_addrs[0]   <= make_addr(1'b1, DIRECTED_TAG, 3'd4);
        read_addrs[1]   <= '0;
        directed_active = 1'b1;
        while (!directed_done) @(posedge clock);
        directed_active = 1'b0;

        repeat (RANDOM_CYCLES) begin
            read_addrs[0] <= make_addr(({$random(seed)} % 8) != 0,
                                       `ITAG_BITS'({$random(seed)} % NUM_TAGS),
                                       3'($random(seed)));
            read_addrs[1] <= make_addr(({$random(seed)} % 8) != 0,
                                       `ITAG_BITS'({$random(seed)} % NUM_TAGS),
                                       3'($random(seed)));
            @(posedge clock);
        end
        @(negedge clock);
        if (error_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            stop_on_failure();
        end
    end

    initial begin
        #((RESET_CYCLES + DIRECTED_LIMIT + RANDOM_CYCLES + 100) * PERIOD);
        $display("Watchdog expired before the test sequence completed");
        stop_on_failure();
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
hw/icache_pkg.sv
hw/icache_line.sv
hw/icache_fill_select.sv
hw/icache_lookup.sv
hw/icache_prefetcher.sv
hw/icache_mshr.sv
hw/icache_subsystem.sv
sim/icache_mem_model.sv
sim/icache_tb.sv
